//--- ks_string.f
hdl/ks_pkg.sv
hdl/trig_debounce.sv
hdl/noise_lfsr.sv
hdl/delay_ram.sv
hdl/loop_filter.sv
hdl/ks_string.sv
dv/ks_string_checker.sv
dv/ks_string_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ks_string testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ks_string_tb \
	-f ks_string.f -o ks_string_sim > build.log 2>&1 \
	&& ./obj_dir/ks_string_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q '^Test OK$' sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- dv/ks_string_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ks_string_tb
	import ks_pkg::*;
();

	localparam int NUM_NOTES     = 7;
	localparam int NUM_GLITCH    = 6;
	localparam int IDLE_CYCLES   = 300;
	localparam int CLK_PERIOD    = 20;
	localparam int ACCEPT_CYCLES = 6; // two sync flops plus four stable cycles

	logic      a_clk;
	logic      reset_n;
	logic      trig;
	sample_t   seed_val;
	filt_sel_t filt_sel;
	addr_t     delay_len;
	sample_t   qout;

	int     errors;
	int     run_idx;
	int     rec_ptr;
	int     rec_q[$];          // qout of the first run
	int     hist[2048];        // qout per cycle of one note
	int     note_seed[NUM_NOTES];
	int     note_len[NUM_NOTES];
	int     note_press[NUM_NOTES];
	int     note_mode[NUM_NOTES];
	int     glitch_len[NUM_GLITCH];
	longint budget_cycles;
	bit     budget_ready;

	ks_string dut_i
	(
		.a_clk     (a_clk),
		.reset_n   (reset_n),
		.trig      (trig),
		.seed_val  (seed_val),
		.filt_sel  (filt_sel),
		.delay_len (delay_len),
		.qout      (qout)
	);

	initial
	begin
		a_clk = 1'b0;
		forever #(CLK_PERIOD / 2) a_clk = ~a_clk;
	end

	function automatic int abs_val(int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int peak_of(int from, int upto);
		int pk;
		pk = 0;
		for (int i = from; i < upto; i++)
		begin
			if (abs_val(hist[i]) > pk)
			begin
				pk = abs_val(hist[i]);
			end
		end
		return pk;
	endfunction

	function automatic int note_cycles(int idx);
		int len_l;
		len_l = (note_len[idx] < 2) ? 2 : note_len[idx];
		return 6 * (len_l + 3) + 24;
	endfunction

	// second run must replay the first one sample by sample
	task automatic sample_cycle(output int q);
		@(negedge a_clk);
		q = qout;
		if (run_idx == 0)
		begin
			rec_q.push_back(q);
		end
		else
		begin
			assert (q == rec_q[rec_ptr])
			else
			begin
				errors++;
				$display("FAIL %0t: rerun qout %0d differs from first run %0d",
					$time, q, rec_q[rec_ptr]);
			end
			rec_ptr++;
		end
	endtask

	task automatic apply_reset();
		reset_n   = 1'b1;
		trig      = 1'b0;
		seed_val  = '0;
		filt_sel  = '0;
		delay_len = '0;
		repeat (2) @(negedge a_clk);
		reset_n = 1'b0;
	endtask

	task automatic check_silence(int cycles);
		int q;
		for (int c = 0; c < cycles; c++)
		begin
			sample_cycle(q);
			assert (q == 0)
			else
			begin
				errors++;
				$display("FAIL %0t: qout %0d while idle", $time, q);
			end
		end
	endtask

	task automatic glitch_test();
		int q;
		for (int g = 0; g < NUM_GLITCH; g++)
		begin
			for (int c = 0; c < glitch_len[g] + 9; c++)
			begin
				sample_cycle(q);
				assert (q == 0)
				else
				begin
					errors++;
					$display("FAIL %0t: glitch of %0d cycles started a note",
						$time, glitch_len[g]);
				end
				trig = (c < glitch_len[g]);
			end
		end
	endtask

	// one press, then bypass periodicity or decaying window peaks
	task automatic run_note(int idx);
		int  len_l;
		int  w;
		int  total;
		int  s0;
		int  pk_cur;
		int  pk_prev;
		bit  any_nz;
		len_l  = (note_len[idx] < 2) ? 2 : note_len[idx];
		w      = len_l + 3;
		total  = note_cycles(idx);
		s0     = ACCEPT_CYCLES + 2 * w;
		any_nz = 1'b0;
		for (int c = 0; c < total; c++)
		begin
			sample_cycle(hist[c]);
			if (c == 0)
			begin
				seed_val  = sample_t'(note_seed[idx]);
				delay_len = addr_t'(note_len[idx]);
				filt_sel  = filt_sel_t'(note_mode[idx]);
			end
			trig = (c < note_press[idx]);
			if (hist[c] != 0 && c >= ACCEPT_CYCLES + w && c < s0)
			begin
				any_nz = 1'b1; // first pass of the new burst
			end
			if (note_mode[idx] == 0 && c >= s0)
			begin
				assert (hist[c] == hist[c - w])
				else
				begin
					errors++;
					$display("FAIL %0t: qout %0d, expected %0d from period %0d",
						$time, hist[c], hist[c - w], w);
				end
			end
			if (note_mode[idx] != 0 && c >= s0 + w - 1 && ((c - s0 + 1) % w) == 0)
			begin
				// filter taps reach two samples past the window
				pk_cur  = peak_of(c - w + 1, c + 1);
				pk_prev = peak_of(c - 2 * w - 1, c - w + 1);
				assert (pk_cur <= pk_prev)
				else
				begin
					errors++;
					$display("FAIL %0t: window peak %0d above previous %0d in mode %0d",
						$time, pk_cur, pk_prev, note_mode[idx]);
				end
			end
		end
		assert (any_nz)
		else
		begin
			errors++;
			$display("FAIL %0t: press produced no burst, note %0d", $time, idx);
		end
	endtask

	initial
	begin
		void'($urandom(32'hba95));
		errors        = 0;
		run_idx       = 0;
		rec_ptr       = 0;
		budget_ready  = 1'b0;
		reset_n       = 1'b1;
		trig          = 1'b0;
		seed_val      = '0;
		filt_sel      = '0;
		delay_len     = '0;
		for (int g = 0; g < NUM_GLITCH; g++)
		begin
			glitch_len[g] = 1 + ($urandom % 3);
		end
		for (int i = 0; i < NUM_NOTES; i++)
		begin
			note_seed[i]  = int'($urandom);
			note_len[i]   = (i < 2) ? i : ($urandom % 201);
			note_press[i] = 8 + ($urandom % 8);
		end
		note_mode = '{0, 0, 0, 1, 2, 3, 0};
		budget_cycles = 3 + IDLE_CYCLES;
		for (int g = 0; g < NUM_GLITCH; g++)
		begin
			budget_cycles += glitch_len[g] + 9;
		end
		for (int i = 0; i < NUM_NOTES; i++)
		begin
			budget_cycles += note_cycles(i);
		end
		budget_cycles = 2 * budget_cycles;
		budget_ready  = 1'b1;
		for (int r = 0; r < 2; r++)
		begin
			run_idx = r;
			apply_reset();
			check_silence(IDLE_CYCLES);
			glitch_test();
			for (int i = 0; i < NUM_NOTES; i++)
			begin
				run_note(i);
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial
	begin
		wait (budget_ready);
		#(budget_cycles * CLK_PERIOD + 5000);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/ks_string_checker.sv
`timescale 1ns/100ps
`default_nettype none

module ks_string_checker
	import ks_pkg::*;
(
	input logic         a_clk,
	input logic         reset_n,
	input logic         pluck,
	input voice_state_t state,
	input addr_t        addr_cnt,
	input addr_t        loop_len,
	input logic         rd_en
);

	a_pluck_single: assert property (@(posedge a_clk) disable iff (reset_n)
		pluck |=> !pluck)
		else $error("pluck held for two cycles");

	a_cnt_range: assert property (@(posedge a_clk) disable iff (reset_n)
		(state != VOICE_IDLE) |-> (addr_cnt < loop_len))
		else $error("address counter beyond latched length");

	a_reset_idle: assert property (@(posedge a_clk)
		reset_n |=> (state == VOICE_IDLE))
		else $error("state not idle after reset");

	a_idle_no_read: assert property (@(posedge a_clk) disable iff (reset_n)
		(state == VOICE_IDLE) |-> !rd_en)
		else $error("read enabled while idle");

endmodule

bind ks_string ks_string_checker checker_i (.*);

`default_nettype wire

//--- hdl/ks_string.sv
`timescale 1ns/100ps
`default_nettype none

module ks_string
	import ks_pkg::*;
(
	input  logic      a_clk,
	input  logic      reset_n,
	input  logic      trig,
	input  sample_t   seed_val,
	input  filt_sel_t filt_sel,
	input  addr_t     delay_len,
	output sample_t   qout
);

	voice_state_t state;
	voice_state_t state_next;
	addr_t        addr_cnt;
	addr_t        cnt_next;
	addr_t        loop_len;    // latched at pluck
	addr_t        len_next;
	addr_t        len_clamp;
	logic         cnt_last;
	logic         rd_en;
	logic         pluck;
	sample_t      noise;
	sample_t      wr_data;     // feedback register
	sample_t      rd_data;
	sample_t      filt_out;

	assign len_clamp = (delay_len < MIN_DELAY_LEN) ? MIN_DELAY_LEN : delay_len;
	assign cnt_last  = (addr_cnt == loop_len - 1'b1);

	always_comb
	begin
		state_next = state;
		case (state)
			VOICE_IDLE:
			begin
				if (pluck)
				begin
					state_next = VOICE_BURST;
				end
			end
			VOICE_BURST:
			begin
				if (pluck)
				begin
					state_next = VOICE_BURST; // restart the fill
				end
				else if (cnt_last)
				begin
					state_next = VOICE_RING;
				end
			end
			VOICE_RING:
			begin
				if (pluck)
				begin
					state_next = VOICE_BURST;
				end
			end
			default:
			begin
				state_next = VOICE_IDLE;
			end
		endcase
	end

	// one counter serves both burst fill and ring wrap
	always_comb
	begin
		cnt_next = addr_cnt;
		len_next = loop_len;
		if (pluck)
		begin
			cnt_next = '0;
			len_next = len_clamp;
		end
		else if (state != VOICE_IDLE)
		begin
			cnt_next = cnt_last ? '0 : addr_cnt + 1'b1;
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state    <= VOICE_IDLE;
			addr_cnt <= '0;
			loop_len <= MIN_DELAY_LEN;
			rd_en    <= 1'b0;
		end
		else
		begin
			state    <= state_next;
			addr_cnt <= cnt_next;
			loop_len <= len_next;
			rd_en    <= (state_next == VOICE_RING);
		end
	end

	// noise while filling, loop output otherwise
	always_ff @(posedge a_clk)
	begin
		if (state_next == VOICE_BURST)
		begin
			wr_data <= noise;
		end
		else
		begin
			wr_data <= filt_out;
		end
	end

	trig_debounce trig_debounce_i
	(
		.a_clk   (a_clk),
		.reset_n (reset_n),
		.trig    (trig),
		.pluck   (pluck)
	);

	noise_lfsr noise_lfsr_i
	(
		.a_clk   (a_clk),
		.reset_n (reset_n),
		.seed    (seed_val),
		.reload  (pluck),
		.noise   (noise)
	);

	delay_ram delay_ram_i
	(
		.a_clk   (a_clk),
		.wr_addr (addr_cnt),
		.wr_data (wr_data),
		.rd_addr (addr_cnt),
		.rd_en   (rd_en),
		.rd_data (rd_data)
	);

	loop_filter loop_filter_i
	(
		.a_clk   (a_clk),
		.reset_n (reset_n),
		.mode    (filt_sel),
		.din     (rd_data),
		.dout    (filt_out)
	);

	assign qout = filt_out;

endmodule

`default_nettype wire

//--- hdl/loop_filter.sv
`timescale 1ns/100ps
`default_nettype none

module loop_filter
	import ks_pkg::*;
(
	input  logic      a_clk,
	input  logic      reset_n,
	input  filt_sel_t mode,
	input  sample_t   din,
	output sample_t   dout
);

	localparam int SUM2_W = SAMPLE_W + 1;
	localparam int SUM3_W = SAMPLE_W + 2;

	sample_t                   x1;
	sample_t                   x2;
	logic signed [SUM2_W-1:0]  sum2;
	logic signed [SUM3_W-1:0]  sum3;
	sample_t                   avg2;
	sample_t                   avg3;
	sample_t                   filt_y;

	assign sum2 = SUM2_W'(din) + SUM2_W'(x1);
	assign sum3 = SUM3_W'(din) + (SUM3_W'(x1) <<< 1) + SUM3_W'(x2);

	assign avg2 = sample_t'(sum2 >>> 1);
	assign avg3 = sample_t'(sum3 >>> 2); // 1-2-1 kernel

	always_comb
	begin
		case (mode)
			FILT_BYPASS:
			begin
				filt_y = din;
			end
			FILT_AVG2:
			begin
				filt_y = avg2;
			end
			FILT_AVG3:
			begin
				filt_y = avg3;
			end
			FILT_INV:
			begin
				filt_y = -avg2; // odd harmonics only
			end
			default:
			begin
				filt_y = avg2;
			end
		endcase
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			x1   <= '0;
			x2   <= '0;
			dout <= '0;
		end
		else
		begin
			x1   <= din;
			x2   <= x1;
			dout <= filt_y;
		end
	end

endmodule

`default_nettype wire

//--- hdl/delay_ram.sv
`timescale 1ns/100ps
`default_nettype none

module delay_ram
	import ks_pkg::*;
(
	input  logic    a_clk,
	input  addr_t   wr_addr,
	input  sample_t wr_data,
	input  addr_t   rd_addr,
	input  logic    rd_en,
	output sample_t rd_data
);

	sample_t mem [RAM_DEPTH];

	// read before write on a shared address
	always_ff @(posedge a_clk)
	begin
		mem[wr_addr] <= wr_data; // written every cycle
		if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
		else
		begin
			rd_data <= '0; // silent outside ring
		end
	end

endmodule

`default_nettype wire

//--- hdl/noise_lfsr.sv
`timescale 1ns/100ps
`default_nettype none

module noise_lfsr
	import ks_pkg::*;
(
	input  logic    a_clk,
	input  logic    reset_n,
	input  sample_t seed,
	input  logic    reload,
	output sample_t noise
);

	logic [SAMPLE_W-1:0] lfsr_q;
	logic [SAMPLE_W-1:0] lfsr_step;
	logic [SAMPLE_W-1:0] seed_safe;

	// all-zero state would never leave zero
	assign seed_safe = (seed == '0) ? {{(SAMPLE_W-1){1'b0}}, 1'b1} : seed;

	// galois form, shift right and fold in taps on lsb
	always_comb
	begin
		lfsr_step = {1'b0, lfsr_q[SAMPLE_W-1:1]};
		if (lfsr_q[0])
		begin
			lfsr_step = lfsr_step ^ LFSR_TAPS;
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n || reload)
		begin
			lfsr_q <= seed_safe;
		end
		else
		begin
			lfsr_q <= lfsr_step;
		end
	end

	assign noise = sample_t'(lfsr_q);

endmodule

`default_nettype wire

//--- hdl/trig_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module trig_debounce
	import ks_pkg::*;
(
	input  logic a_clk,
	input  logic reset_n,
	input  logic trig,
	output logic pluck
);

	logic                       trig_sync_0;
	logic                       trig_sync_1;
	logic                       trig_level;  // accepted level
	logic [DEBOUNCE_CYCLES-1:0] stable_cnt;
	logic                       level_diff;
	logic                       cnt_full;

	assign level_diff = (trig_sync_1 != trig_level);
	assign cnt_full   = &stable_cnt;

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			trig_sync_0 <= 1'b0;
			trig_sync_1 <= 1'b0;
		end
		else
		begin
			trig_sync_0 <= trig;
			trig_sync_1 <= trig_sync_0;
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			stable_cnt <= '0;
			trig_level <= 1'b0;
			pluck      <= 1'b0;
		end
		else
		begin
			pluck <= 1'b0;
			if (!level_diff)
			begin
				stable_cnt <= '0; // level back, start over
			end
			else if (cnt_full)
			begin
				stable_cnt <= '0;
				trig_level <= ~trig_level;
				pluck      <= ~trig_level; // rising edge only
			end
			else
			begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ks_pkg.sv
`default_nettype none

package ks_pkg;

	localparam int SAMPLE_W  = 24;
	localparam int ADDR_W    = 11;
	localparam int FILT_W    = 3;
	localparam int RAM_DEPTH = 1 << ADDR_W;

	typedef logic signed [SAMPLE_W-1:0] sample_t; // audio sample
	typedef logic [ADDR_W-1:0]          addr_t;   // delay line address or length
	typedef logic [FILT_W-1:0]          filt_sel_t;

	typedef enum logic [1:0]
	{
		VOICE_IDLE,
		VOICE_BURST,
		VOICE_RING
	} voice_state_t;

	localparam addr_t MIN_DELAY_LEN = 11'd2;

	// counter width, all ones = 4 stable cycles
	localparam int DEBOUNCE_CYCLES = 2;

	// x^24 + x^23 + x^22 + x^17 + 1
	localparam logic [SAMPLE_W-1:0] LFSR_TAPS = 24'hE10000;

	localparam filt_sel_t FILT_BYPASS = 3'd0;
	localparam filt_sel_t FILT_AVG2   = 3'd1;
	localparam filt_sel_t FILT_AVG3   = 3'd2;
	localparam filt_sel_t FILT_INV    = 3'd3;

endpackage

`default_nettype wire
